//--- ex_isa_pkg.sv
// ISA-level definitions shared by the execute datapath: data width and the ALU and branch opcodes
package ex_isa_pkg;

  // RV64I data path
  localparam int xlen = 64;

  // ALU operation chosen by decode
  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_sll      = 4'd2,
    alu_slt      = 4'd3,
    alu_sltu     = 4'd4,
    alu_xor      = 4'd5,
    alu_srl      = 4'd6,
    alu_sra      = 4'd7,
    alu_or       = 4'd8,
    alu_and      = 4'd9,
    // lui: immediate already shifted and extended by decode
    alu_lui_pass = 4'd10,
    // link value for jal and jalr
    alu_pc_plus4 = 4'd11
  } alu_op_t;

  // branch and jump kind
  typedef enum logic [3:0] {
    bj_none = 4'd0,
    bj_beq  = 4'd1,
    bj_bne  = 4'd2,
    bj_blt  = 4'd3,
    bj_bge  = 4'd4,
    bj_bltu = 4'd5,
    bj_bgeu = 4'd6,
    bj_jal  = 4'd7,
    bj_jalr = 4'd8
  } bj_op_t;

endpackage

//--- ex_pipe_pkg.sv
// Pipeline control widths and memory access field encodings used across the execute subsystem
package ex_pipe_pkg;

  // load field is {unsigned, size[1:0]}
  localparam int load_w = 3;

  // store field is size[1:0]
  localparam int save_w = 2;

  localparam int reg_addr_w = 5;

  // access size encoding, shared by the load and store fields
  localparam logic [1:0] mem_size_b = 2'b00;
  localparam logic [1:0] mem_size_h = 2'b01;
  localparam logic [1:0] mem_size_w = 2'b10;
  localparam logic [1:0] mem_size_d = 2'b11;

  // top bit of the load field selects zero extension
  localparam int load_unsigned_bit = 2;

endpackage

//--- ex_alu.sv
// Combinational RV64I ALU for the execute stage, with word forms and branch compare flags
`timescale 1ns/100ps

module ex_alu import ex_isa_pkg::*; (
  input  logic [xlen-1:0] op1,
  input  logic [xlen-1:0] op2,
  input  alu_op_t         alu_op,
  input  logic            is_word_opt,
  input  logic [xlen-1:0] pc,
  output logic [xlen-1:0] alu_result,
  output logic            eq,
  output logic            lt,
  output logic            ltu
);

  logic [5:0]      shamt;
  logic [31:0]     w_srl;
  logic [31:0]     w_sra;
  logic [xlen-1:0] res;

  // flags always use the full 64-bit operands
  assign eq  = (op1 == op2);
  assign lt  = ($signed(op1) < $signed(op2));
  assign ltu = (op1 < op2);

  // word shifts only take 5 bits of shift amount
  assign shamt = is_word_opt ? {1'b0, op2[4:0]} : op2[5:0];

  // right shifts on the low word need the 32-bit source
  assign w_srl = op1[31:0] >> shamt[4:0];
  assign w_sra = $signed(op1[31:0]) >>> shamt[4:0];

  always_comb begin
    case (alu_op)
      alu_add:      res = op1 + op2;
      alu_sub:      res = op1 - op2;
      alu_sll:      res = op1 << shamt;
      alu_slt:      res = {{(xlen-1){1'b0}}, lt};
      alu_sltu:     res = {{(xlen-1){1'b0}}, ltu};
      alu_xor:      res = op1 ^ op2;
      alu_srl: begin
        if (is_word_opt) begin
          res = {32'b0, w_srl};
        end else begin
          res = op1 >> shamt;
        end
      end
      alu_sra: begin
        if (is_word_opt) begin
          res = {32'b0, w_sra};
        end else begin
          res = $signed(op1) >>> shamt;
        end
      end
      alu_or:       res = op1 | op2;
      alu_and:      res = op1 & op2;
      alu_lui_pass: res = op2;
      alu_pc_plus4: res = pc + 64'd4;
      default:      res = '0;
    endcase
  end

  // word forms keep the low 32 bits, sign-extended
  assign alu_result = is_word_opt ? {{32{res[31]}}, res[31:0]} : res;

endmodule

//--- ex_branch.sv
// Branch and jump resolution for the execute stage; produces the redirect enable and target
`timescale 1ns/100ps

module ex_branch import ex_isa_pkg::*; (
  input  bj_op_t          bj_op,
  input  logic            eq,
  input  logic            lt,
  input  logic            ltu,
  input  logic [xlen-1:0] op1,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] imm,
  input  logic            take,
  output logic            bj_ena,
  output logic [xlen-1:0] new_pc
);

  logic            cond_ok;
  logic [xlen-1:0] jalr_sum;

  always_comb begin
    case (bj_op)
      bj_beq:  cond_ok = eq;
      bj_bne:  cond_ok = !eq;
      bj_blt:  cond_ok = lt;
      bj_bge:  cond_ok = !lt;
      bj_bltu: cond_ok = ltu;
      bj_bgeu: cond_ok = !ltu;
      bj_jal:  cond_ok = 1'b1;
      bj_jalr: cond_ok = 1'b1;
      default: cond_ok = 1'b0;
    endcase
  end

  // only redirect for an instruction actually entering execute
  assign bj_ena = take && cond_ok;

  assign jalr_sum = op1 + imm;

  // jalr target has bit 0 cleared
  assign new_pc = (bj_op == bj_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;

endmodule

//--- ex_forward.sv
// Operand selection at the decode boundary with execute bypass and load-use hazard stall
`timescale 1ns/100ps

module ex_forward import ex_isa_pkg::*; import ex_pipe_pkg::*; (
  input  logic                  id_valid,
  input  logic                  ex_allowin,
  input  logic [reg_addr_w-1:0] rs1_addr,
  input  logic [reg_addr_w-1:0] rs2_addr,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  input  logic [xlen-1:0]       imm,
  input  logic                  use_imm,
  input  logic                  ex_valid_hold,
  input  logic                  ex_rd_ena,
  input  logic                  ex_mem_rd,
  input  logic [reg_addr_w-1:0] ex_rd_addr,
  input  logic [xlen-1:0]       ex_result,
  output logic [xlen-1:0]       op1,
  output logic [xlen-1:0]       op2,
  output logic [xlen-1:0]       store_src,
  output logic                  fwd_valid,
  output logic                  id_allowin
);

  logic            ex_writes;
  logic            hit1;
  logic            hit2;
  logic            hazard;
  logic [xlen-1:0] rs2_fwd;

  // x0 is never a bypass source
  assign ex_writes = ex_valid_hold && ex_rd_ena && (ex_rd_addr != '0);
  assign hit1      = ex_writes && (ex_rd_addr == rs1_addr);
  assign hit2      = ex_writes && (ex_rd_addr == rs2_addr);

  // load data only exists after memory, so stall instead
  assign hazard = ex_mem_rd && (hit1 || hit2);

  assign op1       = hit1 ? ex_result : rs1_data;
  assign rs2_fwd   = hit2 ? ex_result : rs2_data;
  assign op2       = use_imm ? imm : rs2_fwd;
  assign store_src = rs2_fwd;

  assign fwd_valid  = id_valid && !hazard;
  assign id_allowin = ex_allowin && !hazard;

endmodule

//--- ex_stage.sv
// Execute pipeline register with valid/allowin control; computes the ALU result and the redirect
`timescale 1ns/100ps

module ex_stage import ex_isa_pkg::*; import ex_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fwd_valid,
  input  logic                  mem_allowin,
  input  logic [xlen-1:0]       pc,
  input  logic [xlen-1:0]       op1,
  input  logic [xlen-1:0]       op2,
  input  logic [xlen-1:0]       store_src,
  input  logic [xlen-1:0]       imm,
  input  alu_op_t               alu_op,
  input  bj_op_t                bj_op,
  input  logic                  is_word_opt,
  input  logic                  mem_rd_ena,
  input  logic                  mem_wr_ena,
  input  logic [load_w-1:0]     load_info,
  input  logic [save_w-1:0]     save_info,
  input  logic                  rd_ena,
  input  logic [reg_addr_w-1:0] rd_addr,
  output logic                  ex_allowin,
  output logic                  ex_mem_valid,
  output logic                  ex_valid_hold,
  output logic [xlen-1:0]       pc_out,
  output logic [xlen-1:0]       ex_data,
  output logic [xlen-1:0]       mem_wr_src_out,
  output logic [load_w-1:0]     load_info_out,
  output logic [save_w-1:0]     save_info_out,
  output logic                  mem_rd_ena_out,
  output logic                  mem_wr_ena_out,
  output logic                  rd_ena_out,
  output logic [reg_addr_w-1:0] rd_addr_out,
  output logic                  bj_ena,
  output logic [xlen-1:0]       new_pc
);

  logic            ex_valid;
  logic            transfer;
  logic [xlen-1:0] alu_result;
  logic            eq;
  logic            lt;
  logic            ltu;

  // execute finishes in one cycle
  assign ex_allowin    = !ex_valid || mem_allowin;
  assign ex_mem_valid  = ex_valid;
  assign ex_valid_hold = ex_valid;
  assign transfer      = fwd_valid && ex_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= fwd_valid;
    end
  end

  ex_alu alu_i (
    .op1         (op1),
    .op2         (op2),
    .alu_op      (alu_op),
    .is_word_opt (is_word_opt),
    .pc          (pc),
    .alu_result  (alu_result),
    .eq          (eq),
    .lt          (lt),
    .ltu         (ltu)
  );

  ex_branch branch_i (
    .bj_op  (bj_op),
    .eq     (eq),
    .lt     (lt),
    .ltu    (ltu),
    .op1    (op1),
    .pc     (pc),
    .imm    (imm),
    .take   (transfer),
    .bj_ena (bj_ena),
    .new_pc (new_pc)
  );

  // payload holds while memory stalls
  always_ff @(posedge clk) begin
    if (transfer) begin
      pc_out         <= pc;
      ex_data        <= alu_result;
      mem_wr_src_out <= store_src;
      load_info_out  <= load_info;
      save_info_out  <= save_info;
      mem_rd_ena_out <= mem_rd_ena;
      mem_wr_ena_out <= mem_wr_ena;
      rd_ena_out     <= rd_ena;
      rd_addr_out    <= rd_addr;
    end
  end

endmodule

//--- ex_top.sv
// Execute subsystem boundary: joins the decode-side forwarder to the execute stage
`timescale 1ns/100ps

module ex_top import ex_isa_pkg::*; import ex_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  id_valid,
  output logic                  id_allowin,
  input  logic [xlen-1:0]       pc,
  input  logic [reg_addr_w-1:0] rs1_addr,
  input  logic [reg_addr_w-1:0] rs2_addr,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  input  logic [xlen-1:0]       imm,
  input  logic                  use_imm,
  input  logic                  is_word_opt,
  input  alu_op_t               alu_op,
  input  bj_op_t                bj_op,
  input  logic                  mem_rd_ena,
  input  logic                  mem_wr_ena,
  input  logic [load_w-1:0]     load_info,
  input  logic [save_w-1:0]     save_info,
  input  logic                  rd_ena,
  input  logic [reg_addr_w-1:0] rd_addr,
  input  logic                  mem_allowin,
  output logic                  ex_mem_valid,
  output logic [xlen-1:0]       pc_out,
  output logic [xlen-1:0]       ex_data,
  output logic [xlen-1:0]       mem_wr_src_out,
  output logic [load_w-1:0]     load_info_out,
  output logic [save_w-1:0]     save_info_out,
  output logic                  mem_rd_ena_out,
  output logic                  mem_wr_ena_out,
  output logic                  rd_ena_out,
  output logic [reg_addr_w-1:0] rd_addr_out,
  output logic                  bj_ena,
  output logic [xlen-1:0]       new_pc
);

  logic            ex_allowin;
  logic            ex_valid_hold;
  logic            fwd_valid;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] store_src;

  // bypass comes from the instruction held in execute
  ex_forward forward_i (
    .id_valid      (id_valid),
    .ex_allowin    (ex_allowin),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .imm           (imm),
    .use_imm       (use_imm),
    .ex_valid_hold (ex_valid_hold),
    .ex_rd_ena     (rd_ena_out),
    .ex_mem_rd     (mem_rd_ena_out),
    .ex_rd_addr    (rd_addr_out),
    .ex_result     (ex_data),
    .op1           (op1),
    .op2           (op2),
    .store_src     (store_src),
    .fwd_valid     (fwd_valid),
    .id_allowin    (id_allowin)
  );

  ex_stage stage_i (
    .clk            (clk),
    .rst            (rst),
    .fwd_valid      (fwd_valid),
    .mem_allowin    (mem_allowin),
    .pc             (pc),
    .op1            (op1),
    .op2            (op2),
    .store_src      (store_src),
    .imm            (imm),
    .alu_op         (alu_op),
    .bj_op          (bj_op),
    .is_word_opt    (is_word_opt),
    .mem_rd_ena     (mem_rd_ena),
    .mem_wr_ena     (mem_wr_ena),
    .load_info      (load_info),
    .save_info      (save_info),
    .rd_ena         (rd_ena),
    .rd_addr        (rd_addr),
    .ex_allowin     (ex_allowin),
    .ex_mem_valid   (ex_mem_valid),
    .ex_valid_hold  (ex_valid_hold),
    .pc_out         (pc_out),
    .ex_data        (ex_data),
    .mem_wr_src_out (mem_wr_src_out),
    .load_info_out  (load_info_out),
    .save_info_out  (save_info_out),
    .mem_rd_ena_out (mem_rd_ena_out),
    .mem_wr_ena_out (mem_wr_ena_out),
    .rd_ena_out     (rd_ena_out),
    .rd_addr_out    (rd_addr_out),
    .bj_ena         (bj_ena),
    .new_pc         (new_pc)
  );

endmodule

//--- ex_sva.sv
// Concurrent checks for the execute subsystem, bound into ex_top, with its own ALU and branch model
`timescale 1ns/100ps

module ex_sva import ex_isa_pkg::*; import ex_pipe_pkg::*; (
  input logic                  clk,
  input logic                  rst,
  input logic                  id_valid,
  input logic                  id_allowin,
  input logic [xlen-1:0]       pc,
  input logic [reg_addr_w-1:0] rs1_addr,
  input logic [reg_addr_w-1:0] rs2_addr,
  input logic [xlen-1:0]       rs1_data,
  input logic [xlen-1:0]       rs2_data,
  input logic [xlen-1:0]       imm,
  input logic                  use_imm,
  input logic                  is_word_opt,
  input alu_op_t               alu_op,
  input bj_op_t                bj_op,
  input logic                  mem_rd_ena,
  input logic                  mem_wr_ena,
  input logic [load_w-1:0]     load_info,
  input logic [save_w-1:0]     save_info,
  input logic                  rd_ena,
  input logic [reg_addr_w-1:0] rd_addr,
  input logic                  mem_allowin,
  input logic                  ex_allowin,
  input logic                  ex_mem_valid,
  input logic [xlen-1:0]       pc_out,
  input logic [xlen-1:0]       ex_data,
  input logic [xlen-1:0]       mem_wr_src_out,
  input logic [load_w-1:0]     load_info_out,
  input logic [save_w-1:0]     save_info_out,
  input logic                  mem_rd_ena_out,
  input logic                  mem_wr_ena_out,
  input logic                  rd_ena_out,
  input logic [reg_addr_w-1:0] rd_addr_out,
  input logic                  bj_ena,
  input logic [xlen-1:0]       new_pc
);

  int fail_count = 0;

  logic                                      ex_wr;
  logic                                      hit1;
  logic                                      hit2;
  logic                                      xfer;
  logic                                      hold;
  logic                                      load_use;
  logic                                      seen_xfer;
  logic                                      exp_bj;
  logic [xlen-1:0]                           eff1;
  logic [xlen-1:0]                           eff2_reg;
  logic [xlen-1:0]                           eff2;
  logic [xlen-1:0]                           exp_data;
  logic [xlen-1:0]                           exp_data_q;
  logic [xlen-1:0]                           exp_src_q;
  logic [xlen-1:0]                           exp_pc;
  logic [xlen+load_w+save_w+reg_addr_w+2:0]   in_fields;
  logic [xlen+load_w+save_w+reg_addr_w+2:0]   in_fields_q;
  logic [xlen+load_w+save_w+reg_addr_w+2:0]   out_fields;
  logic [3*xlen+load_w+save_w+reg_addr_w+2:0] out_all;
  logic [3*xlen+load_w+save_w+reg_addr_w+2:0] out_all_q;

  function automatic logic [xlen-1:0] model_alu(alu_op_t op, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b, logic word,
                                                logic [xlen-1:0] pc_v);
    logic [31:0]     w;
    logic [xlen-1:0] r;
    w = '0;
    r = '0;
    if (word) begin
      case (op)
        alu_add:      w = a[31:0] + b[31:0];
        alu_sub:      w = a[31:0] - b[31:0];
        alu_sll:      w = a[31:0] << b[4:0];
        alu_slt:      w = {31'b0, ($signed(a) < $signed(b))};
        alu_sltu:     w = {31'b0, (a < b)};
        alu_xor:      w = a[31:0] ^ b[31:0];
        alu_srl:      w = a[31:0] >> b[4:0];
        alu_sra:      w = $signed(a[31:0]) >>> b[4:0];
        alu_or:       w = a[31:0] | b[31:0];
        alu_and:      w = a[31:0] & b[31:0];
        alu_lui_pass: w = b[31:0];
        alu_pc_plus4: w = pc_v[31:0] + 32'd4;
        default:      w = '0;
      endcase
      // word results are sign-extended from bit 31
      r = {{32{w[31]}}, w};
    end else begin
      case (op)
        alu_add:      r = a + b;
        alu_sub:      r = a - b;
        alu_sll:      r = a << b[5:0];
        alu_slt:      r = {63'b0, ($signed(a) < $signed(b))};
        alu_sltu:     r = {63'b0, (a < b)};
        alu_xor:      r = a ^ b;
        alu_srl:      r = a >> b[5:0];
        alu_sra:      r = $signed(a) >>> b[5:0];
        alu_or:       r = a | b;
        alu_and:      r = a & b;
        alu_lui_pass: r = b;
        alu_pc_plus4: r = pc_v + 64'd4;
        default:      r = '0;
      endcase
    end
    return r;
  endfunction

  function automatic logic model_taken(bj_op_t op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (op)
      bj_beq:  return a == b;
      bj_bne:  return a != b;
      bj_blt:  return $signed(a) < $signed(b);
      bj_bge:  return $signed(a) >= $signed(b);
      bj_bltu: return a < b;
      bj_bgeu: return a >= b;
      bj_jal:  return 1'b1;
      bj_jalr: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // bypass from the instruction held in execute
  assign ex_wr    = ex_mem_valid && rd_ena_out && (rd_addr_out != '0);
  assign hit1     = ex_wr && (rd_addr_out == rs1_addr);
  assign hit2     = ex_wr && (rd_addr_out == rs2_addr);
  assign load_use = mem_rd_ena_out && (hit1 || hit2);
  assign eff1     = hit1 ? ex_data : rs1_data;
  assign eff2_reg = hit2 ? ex_data : rs2_data;
  assign eff2     = use_imm ? imm : eff2_reg;

  assign xfer     = id_valid && id_allowin;
  assign hold     = ex_mem_valid && !mem_allowin;
  assign exp_data = model_alu(alu_op, eff1, eff2, is_word_opt, pc);
  assign exp_bj   = model_taken(bj_op, eff1, eff2);
  assign exp_pc   = (bj_op == bj_jalr) ? ((eff1 + imm) & ~64'd1) : (pc + imm);

  assign in_fields  = {pc, load_info, save_info, mem_rd_ena, mem_wr_ena, rd_ena, rd_addr};
  assign out_fields = {pc_out, load_info_out, save_info_out, mem_rd_ena_out, mem_wr_ena_out,
                       rd_ena_out, rd_addr_out};
  assign out_all    = {out_fields, ex_data, mem_wr_src_out};

  always_ff @(posedge clk) begin
    exp_data_q  <= exp_data;
    exp_src_q   <= eff2_reg;
    in_fields_q <= in_fields;
    out_all_q   <= out_all;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      seen_xfer <= 1'b0;
    end else if (xfer) begin
      seen_xfer <= 1'b1;
    end
  end

  reset_idle: assert property (@(posedge clk) disable iff (rst) !seen_xfer |-> !ex_mem_valid)
    else begin
      fail_count++;
      $error("** Error ex_mem_valid: expected 0, got %h", $sampled(ex_mem_valid));
    end

  data_check: assert property (@(posedge clk) disable iff (rst) xfer |=> ex_data == exp_data_q)
    else begin
      fail_count++;
      $error("** Error ex_data: expected %h, got %h", $sampled(exp_data_q), $sampled(ex_data));
    end

  src_check: assert property (@(posedge clk) disable iff (rst)
                              xfer |=> mem_wr_src_out == exp_src_q)
    else begin
      fail_count++;
      $error("** Error mem_wr_src_out: expected %h, got %h",
             $sampled(exp_src_q), $sampled(mem_wr_src_out));
    end

  fields_check: assert property (@(posedge clk) disable iff (rst)
                                 xfer |=> out_fields == in_fields_q)
    else begin
      fail_count++;
      $error("** Error pass-through fields: expected %h, got %h",
             $sampled(in_fields_q), $sampled(out_fields));
    end

  valid_after: assert property (@(posedge clk) disable iff (rst) xfer |=> ex_mem_valid)
    else begin
      fail_count++;
      $error("** Error ex_mem_valid: expected 1, got %h", $sampled(ex_mem_valid));
    end

  bj_check: assert property (@(posedge clk) disable iff (rst) xfer |-> bj_ena == exp_bj)
    else begin
      fail_count++;
      $error("** Error bj_ena: expected %h, got %h", $sampled(exp_bj), $sampled(bj_ena));
    end

  pc_check: assert property (@(posedge clk) disable iff (rst)
                             xfer && exp_bj |-> new_pc == exp_pc)
    else begin
      fail_count++;
      $error("** Error new_pc: expected %h, got %h", $sampled(exp_pc), $sampled(new_pc));
    end

  bj_idle: assert property (@(posedge clk) disable iff (rst) !xfer |-> !bj_ena)
    else begin
      fail_count++;
      $error("** Error bj_ena: expected 0, got %h", $sampled(bj_ena));
    end

  hold_stable: assert property (@(posedge clk) disable iff (rst) hold |=> out_all == out_all_q)
    else begin
      fail_count++;
      $error("** Error registered outputs: expected %h, got %h",
             $sampled(out_all_q), $sampled(out_all));
    end

  hold_allowin: assert property (@(posedge clk) disable iff (rst) hold |-> !ex_allowin)
    else begin
      fail_count++;
      $error("** Error ex_allowin: expected 0, got %h", $sampled(ex_allowin));
    end

  load_stall: assert property (@(posedge clk) disable iff (rst) load_use |-> !id_allowin)
    else begin
      fail_count++;
      $error("** Error id_allowin: expected 0, got %h", $sampled(id_allowin));
    end

endmodule

bind ex_top ex_sva sva_i (.*);

//--- ex_tb.sv
// Testbench for the execute subsystem; drives random and directed instructions, bound assertions check
`timescale 1ns/100ps

module ex_tb import ex_isa_pkg::*; import ex_pipe_pkg::*; ();

  localparam int seed          = 95804;
  localparam int period        = 8;
  localparam int reset_cycles  = 16;
  localparam int random_count  = 300;
  // reset, random phase and about 50 directed instructions fit well inside this
  localparam int cycle_limit   = 2000;

  logic                  clk;
  logic                  rst;
  logic                  id_valid;
  logic                  id_allowin;
  logic [xlen-1:0]       pc;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       imm;
  logic                  use_imm;
  logic                  is_word_opt;
  alu_op_t               alu_op;
  bj_op_t                bj_op;
  logic                  mem_rd_ena;
  logic                  mem_wr_ena;
  logic [load_w-1:0]     load_info;
  logic [save_w-1:0]     save_info;
  logic                  rd_ena;
  logic [reg_addr_w-1:0] rd_addr;
  logic                  mem_allowin;
  logic                  ex_mem_valid;
  logic [xlen-1:0]       pc_out;
  logic [xlen-1:0]       ex_data;
  logic [xlen-1:0]       mem_wr_src_out;
  logic [load_w-1:0]     load_info_out;
  logic [save_w-1:0]     save_info_out;
  logic                  mem_rd_ena_out;
  logic                  mem_wr_ena_out;
  logic                  rd_ena_out;
  logic [reg_addr_w-1:0] rd_addr_out;
  logic                  bj_ena;
  logic [xlen-1:0]       new_pc;
  int                    cycles;

  ex_top ex_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic stop_with_fail(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic set_idle();
    id_valid    = 1'b0;
    mem_allowin = 1'b1;
    pc          = '0;
    rs1_addr    = '0;
    rs2_addr    = '0;
    rs1_data    = '0;
    rs2_data    = '0;
    imm         = '0;
    use_imm     = 1'b0;
    is_word_opt = 1'b0;
    alu_op      = alu_add;
    bj_op       = bj_none;
    mem_rd_ena  = 1'b0;
    mem_wr_ena  = 1'b0;
    load_info   = '0;
    save_info   = '0;
    rd_ena      = 1'b0;
    rd_addr     = '0;
  endtask

  // few register numbers so bypass and load-use hits are common
  task automatic drive_random();
    id_valid    = ($urandom_range(0, 3) != 0);
    mem_allowin = ($urandom_range(0, 3) != 0);
    pc          = {$urandom, $urandom};
    rs1_addr    = reg_addr_w'($urandom_range(0, 7));
    rs2_addr    = reg_addr_w'($urandom_range(0, 7));
    rs1_data    = {$urandom, $urandom};
    rs2_data    = {$urandom, $urandom};
    imm         = {$urandom, $urandom};
    use_imm     = ($urandom_range(0, 1) == 1);
    is_word_opt = ($urandom_range(0, 1) == 1);
    alu_op      = alu_op_t'(4'($urandom_range(0, 11)));
    bj_op       = bj_op_t'(4'($urandom_range(0, 8)));
    mem_rd_ena  = ($urandom_range(0, 3) == 0);
    mem_wr_ena  = ($urandom_range(0, 3) == 0);
    load_info   = load_w'($urandom_range(0, 7));
    save_info   = save_w'($urandom_range(0, 3));
    rd_ena      = ($urandom_range(0, 3) != 0);
    rd_addr     = reg_addr_w'($urandom_range(0, 7));
  endtask

  // present one instruction and hold it until decode may advance
  task automatic issue(input alu_op_t op, input bj_op_t bj, input logic [reg_addr_w-1:0] rs1,
                       input logic [reg_addr_w-1:0] rs2, input logic [reg_addr_w-1:0] rd,
                       input logic [xlen-1:0] d1, input logic [xlen-1:0] d2,
                       input logic load);
    logic accepted;
    accepted    = 1'b0;
    id_valid    = 1'b1;
    mem_allowin = 1'b1;
    pc          = pc + 64'd4;
    alu_op      = op;
    bj_op       = bj;
    rs1_addr    = rs1;
    rs2_addr    = rs2;
    rd_addr     = rd;
    rd_ena      = (rd != '0);
    rs1_data    = d1;
    rs2_data    = d2;
    imm         = 64'd16;
    use_imm     = 1'b0;
    is_word_opt = 1'b0;
    mem_rd_ena  = load;
    while (!accepted) begin
      #1;
      accepted = id_allowin;
      @(negedge clk);
    end
    id_valid = 1'b0;
  endtask

  initial begin
    cycles = 0;
    forever begin
      @(negedge clk);
      cycles++;
      if (ex_top_i.sva_i.fail_count != 0) begin
        stop_with_fail("an assertion failed, see the error above");
      end else if (cycles >= cycle_limit) begin
        stop_with_fail("timeout: test sequence not done within the cycle limit");
      end
    end
  end

  initial begin
    void'($urandom(seed));
    set_idle();
    rst = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    repeat (random_count) begin
      @(negedge clk);
      drive_random();
    end
    @(negedge clk);
    set_idle();
    repeat (4) @(negedge clk);

    // back-to-back dependent pairs through the bypass
    issue(alu_add, bj_none, 5'd1, 5'd2, 5'd3, 64'h10, 64'h20, 1'b0);
    issue(alu_sub, bj_none, 5'd3, 5'd3, 5'd4, 64'h0, 64'h0, 1'b0);
    issue(alu_xor, bj_none, 5'd2, 5'd4, 5'd4, 64'h55, 64'h0, 1'b0);
    // load-use pairs stall decode for one cycle
    issue(alu_add, bj_none, 5'd1, 5'd2, 5'd5, 64'h100, 64'h8, 1'b1);
    issue(alu_or, bj_none, 5'd5, 5'd6, 5'd6, 64'h0, 64'hf0, 1'b0);
    issue(alu_add, bj_none, 5'd1, 5'd2, 5'd7, 64'h200, 64'h4, 1'b1);
    issue(alu_and, bj_none, 5'd6, 5'd7, 5'd0, 64'hff, 64'h0, 1'b0);

    // equal, less, greater and signed-versus-unsigned operands for each branch
    for (int op = 1; op <= 8; op++) begin
      issue(alu_pc_plus4, bj_op_t'(4'(op)), 5'd8, 5'd9, 5'd0, 64'd7, 64'd7, 1'b0);
      issue(alu_pc_plus4, bj_op_t'(4'(op)), 5'd8, 5'd9, 5'd0, 64'd5, 64'd9, 1'b0);
      issue(alu_pc_plus4, bj_op_t'(4'(op)), 5'd8, 5'd9, 5'd0, 64'd9, 64'd5, 1'b0);
      issue(alu_pc_plus4, bj_op_t'(4'(op)), 5'd8, 5'd9, 5'd0, '1, 64'd1, 1'b0);
    end

    set_idle();
    repeat (4) @(negedge clk);
    if (ex_top_i.sva_i.fail_count != 0) begin
      stop_with_fail("assertion checks failed during the run");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- build.f
ex_isa_pkg.sv
ex_pipe_pkg.sv
ex_alu.sv
ex_branch.sv
ex_forward.sv
ex_stage.sv
ex_top.sv
ex_sva.sv
ex_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := ex_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0
RUN_FLAGS := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
